// ==== source/lsu_macros.svh ====
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// Register and address width
`define LSU_XLEN 32

// ROB tag width, tags wrap modulo 2**LSU_TAG_WIDTH
`define LSU_TAG_WIDTH 4

// Number of CDB broadcast ports
`define LSU_PIPE_WIDTH 2

// Store queue entries
`define LSU_STQ_DEPTH 4

`endif

// ==== source/isa_pkg.sv ====
`default_nettype none

`include "lsu_macros.svh"

package isa_pkg;

    // One register value
    typedef logic [`LSU_XLEN-1:0] data_t;

    // Byte address in memory
    typedef logic [`LSU_XLEN-1:0] addr_t;

    // I-type offset, sign-extended by the AGU
    typedef logic signed [11:0] imm_t;

    // Access size of a load or store
    typedef enum logic [1:0] {
        MEM_BYTE,
        MEM_HALF,
        MEM_WORD
    } mem_width_t;

endpackage

`default_nettype wire

// ==== source/uarch_pkg.sv ====
`default_nettype none

`include "lsu_macros.svh"

package uarch_pkg;

    import isa_pkg::*;

    // ROB entry tag
    typedef logic [`LSU_TAG_WIDTH-1:0] tag_t;

    // Source operand, either a value or the tag that will produce it
    typedef struct packed {
        logic  rdy;
        tag_t  tag;
        data_t data;
    } operand_t;

    // Memory instruction as held in the station
    // Once addr_done is set, base.data holds the effective address
    typedef struct packed {
        logic       valid;
        tag_t       dest_tag;
        operand_t   base;
        imm_t       imm;
        mem_width_t width;
        logic       addr_done;
    } mem_instr_t;

    // Result broadcast, used on the CDB and for the AGU return
    typedef struct packed {
        logic  valid;
        tag_t  tag;
        data_t result;
    } wb_pkt_t;

    // One in-flight store
    typedef struct packed {
        logic  valid;
        tag_t  tag;
        logic  addr_known;
        addr_t addr;
    } stq_entry_t;

endpackage

`default_nettype wire

// ==== source/operand_station.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lsu_macros.svh"

module operand_station (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        flush,
    input  wire uarch_pkg::mem_instr_t entry,
    input  wire                        we,
    input  wire                        release_entry,
    input  wire uarch_pkg::wb_pkt_t    cdb [`LSU_PIPE_WIDTH],
    output uarch_pkg::mem_instr_t      held,
    output logic                       busy,
    output logic                       operand_rdy
);

    import uarch_pkg::*;

    mem_instr_t next_entry;

    always_comb begin
        // A new write replaces whatever is held
        next_entry = we ? entry : held;

        // Snoop the CDB for the base operand, also on the write cycle
        if (next_entry.valid && !next_entry.base.rdy) begin
            for (int p = 0; p < `LSU_PIPE_WIDTH; p++) begin
                if (cdb[p].valid && (cdb[p].tag == next_entry.base.tag)) begin
                    next_entry.base.rdy  = 1'b1;
                    next_entry.base.data = cdb[p].result;
                end
            end
        end

        // Entry leaves unless it is refilled in the same cycle
        if (release_entry && !we) begin
            next_entry = '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held <= '0;
        end else if (flush) begin
            held <= '0;
        end else begin
            held <= next_entry;
        end
    end

    assign busy        = held.valid;
    assign operand_rdy = held.valid && held.base.rdy;

endmodule

`default_nettype wire

// ==== source/addr_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lsu_macros.svh"

module addr_gen (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        flush,
    input  wire                        req,
    input  wire uarch_pkg::mem_instr_t pkt,
    output uarch_pkg::wb_pkt_t         wb
);

    import isa_pkg::*;
    import uarch_pkg::*;

    localparam int IMM_W = $bits(imm_t);

    logic  valid_q;
    tag_t  tag_q;
    data_t sum_q;
    data_t imm_ext;

    // Sign-extend the offset to full width
    assign imm_ext = {{(`LSU_XLEN - IMM_W){pkt.imm[IMM_W-1]}}, pkt.imm};

    // One-cycle valid per request, dropped on flush
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= req && !flush;
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            tag_q <= pkt.dest_tag;
            sum_q <= pkt.base.data + imm_ext;
        end
    end

    always_comb begin
        wb.valid  = valid_q;
        wb.tag    = tag_q;
        wb.result = sum_q;
    end

endmodule

`default_nettype wire

// ==== source/store_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lsu_macros.svh"

module store_queue (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   flush,
    input  wire                   st_we,
    input  wire uarch_pkg::tag_t  st_tag,
    input  wire                   st_addr_we,
    input  wire uarch_pkg::tag_t  st_addr_tag,
    input  wire isa_pkg::addr_t   st_addr,
    input  wire                   st_retire,
    output logic                  st_write_rdy,
    output uarch_pkg::stq_entry_t entries [`LSU_STQ_DEPTH]
);

    localparam int DEPTH = `LSU_STQ_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;

    ptr_t head;
    ptr_t tail;
    cnt_t count;
    logic push;
    logic pop;

    // Wrap at DEPTH, which need not be a power of two
    function automatic ptr_t ptr_inc(input ptr_t p);
        return (p == ptr_t'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign st_write_rdy = (count != cnt_t'(DEPTH));
    assign push         = st_we && st_write_rdy;
    assign pop          = st_retire && (count != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                entries[i] <= '0;
            end
        end else if (flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            // Address resolve by tag match
            if (st_addr_we) begin
                for (int i = 0; i < DEPTH; i++) begin
                    if (entries[i].valid && (entries[i].tag == st_addr_tag)) begin
                        entries[i].addr_known <= 1'b1;
                        entries[i].addr       <= st_addr;
                    end
                end
            end

            if (push) begin
                entries[tail].valid      <= 1'b1;
                entries[tail].tag        <= st_tag;
                entries[tail].addr_known <= 1'b0;
                tail                     <= ptr_inc(tail);
            end

            // Oldest store leaves at retire
            if (pop) begin
                entries[head].valid <= 1'b0;
                head                <= ptr_inc(head);
            end

            count <= count + cnt_t'(push) - cnt_t'(pop);
        end
    end

endmodule

`default_nettype wire

// ==== source/load_station.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lsu_macros.svh"

module load_station (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        flush,
    input  wire uarch_pkg::mem_instr_t ld_entry,
    input  wire                        ld_we,
    output logic                       ld_write_rdy,
    input  wire uarch_pkg::wb_pkt_t    cdb [`LSU_PIPE_WIDTH],
    output logic                       mem_req,
    output uarch_pkg::mem_instr_t      mem_pkt,
    input  wire                        mem_grant,
    input  wire uarch_pkg::stq_entry_t stq_entries [`LSU_STQ_DEPTH],
    input  wire uarch_pkg::tag_t       rob_head
);

    import uarch_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_OPERAND,
        WAIT_ADDR,
        READY
    } state_t;

    state_t     state;
    state_t     next_state;

    mem_instr_t held;
    mem_instr_t station_entry;
    mem_instr_t agu_entry;
    wb_pkt_t    agu_wb;

    logic       station_we;
    logic       station_busy;
    logic       operand_rdy;
    logic       dispatch;
    logic       agu_req;
    logic       agu_we;
    logic       issue;
    logic       alias_hit;
    tag_t       load_age;

    operand_station operand_station_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush         (flush),
        .entry         (station_entry),
        .we            (station_we),
        .release_entry (issue),
        .cdb           (cdb),
        .held          (held),
        .busy          (station_busy),
        .operand_rdy   (operand_rdy)
    );

    addr_gen addr_gen_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .flush (flush),
        .req   (agu_req),
        .pkt   (held),
        .wb    (agu_wb)
    );

    assign issue        = mem_req && mem_grant;
    assign ld_write_rdy = !station_busy || issue;
    assign dispatch     = ld_we && ld_write_rdy;

    // AGU result belongs to the held load
    assign agu_we = (state == WAIT_ADDR) && agu_wb.valid && (agu_wb.tag == held.dest_tag);

    always_comb begin
        agu_entry           = held;
        agu_entry.base.data = agu_wb.result;
        agu_entry.addr_done = 1'b1;
    end

    // Single write port, dispatch first
    assign station_we    = dispatch || agu_we;
    assign station_entry = dispatch ? ld_entry : agu_entry;

    // Age as distance from the ROB head, wraps with the tag width
    assign load_age = held.dest_tag - rob_head;

    always_comb begin
        alias_hit = 1'b0;
        for (int i = 0; i < `LSU_STQ_DEPTH; i++) begin
            if (stq_entries[i].valid &&
                (tag_t'(stq_entries[i].tag - rob_head) < load_age)) begin
                // Unknown address may alias anything
                if (!stq_entries[i].addr_known ||
                    (stq_entries[i].addr[`LSU_XLEN-1:2] == held.base.data[`LSU_XLEN-1:2])) begin
                    alias_hit = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else if (flush) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        agu_req    = 1'b0;
        case (state)
            IDLE: begin
                if (dispatch) begin
                    next_state = WAIT_OPERAND;
                end
            end
            WAIT_OPERAND: begin
                if (operand_rdy) begin
                    agu_req    = 1'b1;
                    next_state = WAIT_ADDR;
                end
            end
            WAIT_ADDR: begin
                if (agu_we) begin
                    next_state = READY;
                end
            end
            READY: begin
                if (issue) begin
                    next_state = dispatch ? WAIT_OPERAND : IDLE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    assign mem_req = (state == READY) && !alias_hit;
    assign mem_pkt = held;

endmodule

`default_nettype wire

// ==== source/load_issue_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lsu_macros.svh"

module load_issue_top (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        flush,
    input  wire uarch_pkg::mem_instr_t ld_entry,
    input  wire                        ld_we,
    output logic                       ld_write_rdy,
    input  wire                        st_we,
    input  wire uarch_pkg::tag_t       st_tag,
    output logic                       st_write_rdy,
    input  wire                        st_addr_we,
    input  wire uarch_pkg::tag_t       st_addr_tag,
    input  wire isa_pkg::addr_t        st_addr,
    input  wire                        st_retire,
    input  wire uarch_pkg::wb_pkt_t    cdb [`LSU_PIPE_WIDTH],
    output logic                       mem_req,
    output uarch_pkg::mem_instr_t      mem_pkt,
    input  wire                        mem_grant,
    input  wire uarch_pkg::tag_t       rob_head
);

    import uarch_pkg::*;

    stq_entry_t stq_entries [`LSU_STQ_DEPTH];

    load_station load_station_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .ld_entry     (ld_entry),
        .ld_we        (ld_we),
        .ld_write_rdy (ld_write_rdy),
        .cdb          (cdb),
        .mem_req      (mem_req),
        .mem_pkt      (mem_pkt),
        .mem_grant    (mem_grant),
        .stq_entries  (stq_entries),
        .rob_head     (rob_head)
    );

    store_queue store_queue_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .st_we        (st_we),
        .st_tag       (st_tag),
        .st_addr_we   (st_addr_we),
        .st_addr_tag  (st_addr_tag),
        .st_addr      (st_addr),
        .st_retire    (st_retire),
        .st_write_rdy (st_write_rdy),
        .entries      (stq_entries)
    );

endmodule

`default_nettype wire

// ==== dv/load_issue_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lsu_macros.svh"

module load_issue_tb;

    import isa_pkg::*;
    import uarch_pkg::*;

    // All tests together take a few hundred cycles
    localparam int CYCLE_LIMIT = 2000;

    logic       clk;
    logic       rst_n;
    logic       flush;
    mem_instr_t ld_entry;
    logic       ld_we;
    logic       ld_write_rdy;
    logic       st_we;
    tag_t       st_tag;
    logic       st_write_rdy;
    logic       st_addr_we;
    tag_t       st_addr_tag;
    addr_t      st_addr;
    logic       st_retire;
    wb_pkt_t    cdb [`LSU_PIPE_WIDTH];
    logic       mem_req;
    mem_instr_t mem_pkt;
    logic       mem_grant;
    tag_t       rob_head;

    string      test_name;
    integer     seed;
    int         cycle_count = 0;
    int         error_count = 0;
    addr_t      pend_addr;
    tag_t       pend_tag;
    addr_t      cur_addr;
    tag_t       cur_tag;
    logic       model_alias;
    stq_entry_t model_stq [$];

    load_issue_top load_issue_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TB FAILED");
            $fatal(1);
        end
    end

    // Expected address and tag of the load now in the station
    always @(posedge clk) begin
        if (ld_we && ld_write_rdy) begin
            cur_addr <= pend_addr;
            cur_tag  <= pend_tag;
        end
    end

    // Store queue model, oldest store at the front
    always @(posedge clk) begin : store_model
        stq_entry_t st;
        logic       room;
        room = (model_stq.size() < `LSU_STQ_DEPTH);
        if (!rst_n || flush) begin
            model_stq.delete();
        end else begin
            if (st_addr_we) begin
                foreach (model_stq[i]) begin
                    if (model_stq[i].tag == st_addr_tag) begin
                        model_stq[i].addr_known = 1'b1;
                        model_stq[i].addr       = st_addr;
                    end
                end
            end
            if (st_retire && (model_stq.size() > 0)) begin
                void'(model_stq.pop_front());
            end
            if (st_we && room) begin
                st = '{valid: 1'b1, tag: st_tag, addr_known: 1'b0, addr: '0};
                model_stq.push_back(st);
            end
        end
    end

    // Age is tag distance from the ROB head, modulo the tag width
    always @(negedge clk) begin : alias_model
        tag_t load_dist;
        tag_t store_dist;
        load_dist   = cur_tag - rob_head;
        model_alias = 1'b0;
        foreach (model_stq[i]) begin
            store_dist = model_stq[i].tag - rob_head;
            if ((store_dist < load_dist) && (!model_stq[i].addr_known ||
                (model_stq[i].addr[31:2] == cur_addr[31:2]))) begin
                model_alias = 1'b1;
            end
        end
    end

    issue_check: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_req && mem_grant) |->
            (mem_pkt.dest_tag == cur_tag) && (mem_pkt.base.data == cur_addr) &&
            mem_pkt.addr_done)
    else begin
        error_count++;
        $display("[FAIL] %s: issue expected tag %0d addr 0x%08h, actual tag %0d addr 0x%08h",
                 test_name, $sampled(cur_tag), $sampled(cur_addr),
                 $sampled(mem_pkt.dest_tag), $sampled(mem_pkt.base.data));
        $display("TB FAILED");
        $fatal(1);
    end

    no_alias_check: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req |-> !model_alias)
    else begin
        error_count++;
        $display("[FAIL] %s: mem_req with older aliasing store, expected 0, actual 1",
                 test_name);
        $display("TB FAILED");
        $fatal(1);
    end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic report_mismatch(input string what, input logic [63:0] expected,
                                   input logic [63:0] actual);
        error_count++;
        $display("[FAIL] %s: %s expected 0x%0h, actual 0x%0h", test_name, what, expected, actual);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_eq(input string what, input logic [63:0] expected,
                            input logic [63:0] actual);
        assert (actual === expected) else report_mismatch(what, expected, actual);
    endtask

    task automatic dispatch_load(input tag_t tag, input logic rdy, input tag_t src,
                                 input data_t base, input imm_t imm);
        ld_entry           = '0;
        ld_entry.valid     = 1'b1;
        ld_entry.dest_tag  = tag;
        ld_entry.base.rdy  = rdy;
        ld_entry.base.tag  = src;
        ld_entry.base.data = rdy ? base : '0;
        ld_entry.imm       = imm;
        ld_entry.width     = MEM_WORD;
        // Base plus offset sign-extended to a full word
        pend_addr = base + addr_t'(int'(imm));
        pend_tag  = tag;
        ld_we     = 1'b1;
        @(negedge clk);
        check_eq("ld_write_rdy at dispatch", 1, ld_write_rdy);
        step();
        ld_we = 1'b0;
    endtask

    // Counts cycles from the last write until mem_req is seen
    task automatic wait_req(output int cycles);
        cycles = 1;
        @(negedge clk);
        while (!mem_req) begin
            @(negedge clk);
            cycles++;
        end
        step();
    endtask

    task automatic hold_low(input int n);
        repeat (n) begin
            @(negedge clk);
            check_eq("mem_req while blocked", 0, mem_req);
            step();
        end
    endtask

    // Other port carries a different tag in the same cycle
    task automatic broadcast(input int port, input tag_t tag, input data_t value);
        int other;
        other = (port + 1) % `LSU_PIPE_WIDTH;
        cdb[port]  = '{valid: 1'b1, tag: tag, result: value};
        cdb[other] = '{valid: 1'b1, tag: tag + 1'b1, result: ~value};
        step();
        cdb[port].valid  = 1'b0;
        cdb[other].valid = 1'b0;
    endtask

    task automatic push_store(input tag_t tag);
        st_we  = 1'b1;
        st_tag = tag;
        step();
        st_we  = 1'b0;
    endtask

    task automatic resolve_store(input tag_t tag, input addr_t addr);
        st_addr_we  = 1'b1;
        st_addr_tag = tag;
        st_addr     = addr;
        step();
        st_addr_we  = 1'b0;
    endtask

    task automatic retire_store();
        st_retire = 1'b1;
        step();
        st_retire = 1'b0;
    endtask

    initial begin
        int         lat;
        addr_t      a;
        mem_instr_t saved;
        seed        = 51504;
        rst_n       = 1'b0;
        flush       = 1'b0;
        ld_entry    = '0;
        ld_we       = 1'b0;
        st_we       = 1'b0;
        st_tag      = '0;
        st_addr_we  = 1'b0;
        st_addr_tag = '0;
        st_addr     = '0;
        st_retire   = 1'b0;
        mem_grant   = 1'b1;
        rob_head    = '0;
        foreach (cdb[p]) begin
            cdb[p] = '0;
        end
        test_name = "reset";
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        step();

        test_name = "ready_base";
        a = 32'h1000_0000 | (addr_t'($random(seed)) & 32'h0000_fffc);
        dispatch_load(4'd3, 1'b1, 4'd0, a, -12'sd8);
        wait_req(lat);
        check_eq("cycles from dispatch to mem_req", 3, lat);

        test_name = "cdb_wakeup";
        for (int p = 0; p < `LSU_PIPE_WIDTH; p++) begin
            a = addr_t'($random(seed));
            dispatch_load(tag_t'(5 + p), 1'b0, 4'd9, a, 12'sd16);
            hold_low(5);
            broadcast(p, 4'd9, a);
            wait_req(lat);
            check_eq("cycles from CDB match to mem_req", 3, lat);
        end

        // Head at 14, so store 2 is younger than load 1 after the wrap
        test_name = "older_store_alias";
        rob_head = 4'd14;
        a = 32'h2000_0000 | (addr_t'($random(seed)) & 32'h0000_fff0);
        push_store(4'd15);
        push_store(4'd2);
        dispatch_load(4'd1, 1'b1, 4'd0, a, 12'sd0);
        hold_low(6);
        resolve_store(4'd2, a);
        hold_low(4);
        resolve_store(4'd15, a + 32'd8);
        wait_req(lat);

        test_name = "same_word_store";
        dispatch_load(4'd4, 1'b1, 4'd0, a + 32'd8, 12'sd1);
        hold_low(6);
        retire_store();
        wait_req(lat);
        retire_store();

        test_name = "back_pressure";
        rob_head  = 4'd0;
        mem_grant = 1'b0;
        a = addr_t'($random(seed));
        dispatch_load(4'd6, 1'b1, 4'd0, a, 12'sh7f0);
        wait_req(lat);
        saved = mem_pkt;
        repeat (5) begin
            @(negedge clk);
            check_eq("mem_req under back-pressure", 1, mem_req);
            check_eq("mem_pkt under back-pressure", saved, mem_pkt);
            check_eq("ld_write_rdy while busy", 0, ld_write_rdy);
            step();
        end
        // Grant and the next dispatch in the same cycle
        mem_grant = 1'b1;
        a = addr_t'($random(seed));
        dispatch_load(4'd7, 1'b1, 4'd0, a, 12'sd4);
        wait_req(lat);
        check_eq("cycles from dispatch on grant to mem_req", 3, lat);

        test_name = "flush";
        mem_grant = 1'b0;
        // Full queue, so only the flush can free it
        for (int i = 0; i < `LSU_STQ_DEPTH; i++) begin
            push_store(tag_t'(8 + i));
        end
        dispatch_load(4'd5, 1'b1, 4'd0, a, 12'sd0);
        wait_req(lat);
        flush = 1'b1;
        step();
        flush = 1'b0;
        @(negedge clk);
        check_eq("mem_req after flush", 0, mem_req);
        check_eq("ld_write_rdy after flush", 1, ld_write_rdy);
        check_eq("st_write_rdy after flush", 1, st_write_rdy);
        step();
        mem_grant = 1'b1;
        test_name = "after_flush";
        a = addr_t'($random(seed));
        dispatch_load(4'd10, 1'b1, 4'd0, a, -12'sd1);
        wait_req(lat);
        check_eq("cycles from dispatch to mem_req", 3, lat);

        // Queue must be empty after the flush to take all entries
        test_name = "store_queue_full";
        for (int i = 1; i <= `LSU_STQ_DEPTH; i++) begin
            push_store(tag_t'(i));
            @(negedge clk);
            check_eq("st_write_rdy after push", (i < `LSU_STQ_DEPTH), st_write_rdy);
            step();
        end
        retire_store();
        @(negedge clk);
        check_eq("st_write_rdy after retire", 1, st_write_rdy);
        step();
        repeat (`LSU_STQ_DEPTH - 1) retire_store();

        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+source
source/isa_pkg.sv
source/uarch_pkg.sv
source/operand_station.sv
source/addr_gen.sv
source/store_queue.sv
source/load_station.sv
source/load_issue_top.sv
dv/load_issue_tb.sv

// ==== Bender.yml ====
package:
  name: load_issue

sources:
  - target: any(rtl, test)
    include_dirs:
      - source
    files:
      - source/isa_pkg.sv
      - source/uarch_pkg.sv
      - source/operand_station.sv
      - source/addr_gen.sv
      - source/store_queue.sv
      - source/load_station.sv
      - source/load_issue_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/load_issue_tb.sv
